/* crc_pkg.sv */
package crc_pkg;

	////////////////////////////////////////
	// Register map
	////////////////////////////////////////

	// Word offsets taken from HADDR[4:2]
	localparam logic [2:0] CRC_DR   = 3'd0;
	localparam logic [2:0] CRC_IDR  = 3'd1;
	localparam logic [2:0] CRC_CR   = 3'd2;
	localparam logic [2:0] CRC_INIT = 3'd4;
	localparam logic [2:0] CRC_POL  = 3'd5;

	// Reset values
	localparam logic [4:0]  RESET_CRC_CR   = 5'h00;
	localparam logic [31:0] RESET_CRC_INIT = 32'hFFFF_FFFF;
	localparam logic [31:0] RESET_CRC_POL  = 32'h04C1_1DB7;
	localparam logic [7:0]  RESET_CRC_IDR  = 8'h00;

	// Input FIFO depth
	localparam int BUF_DEPTH = 2;

	////////////////////////////////////////
	// Encodings
	////////////////////////////////////////

	// AHB transfer type
	typedef enum logic [1:0] {HT_IDLE, HT_BUSY, HT_NONSEQ, HT_SEQ} htrans_t;

	// Data size, low two bits of HSIZE
	typedef enum logic [1:0] {SZ_BYTE, SZ_HALF, SZ_WORD} bus_size_t;

	// Polynomial width select, CR bits 4:3
	typedef enum logic [1:0] {PS_32, PS_16, PS_8, PS_7} poly_size_t;

	// Input bit reversal, CR bits 6:5
	typedef enum logic [1:0] {RI_NONE, RI_BYTE, RI_HALF, RI_WORD} rev_in_t;

	// Compute unit FSM
	typedef enum logic {CS_IDLE, CS_RUN} comp_state_t;

endpackage

/* crc_host_interface.sv */
`timescale 1ns/1ps

module crc_host_interface
(
	input  logic                    HCLK,
	input  logic                    HRESETn,
	input  logic                    HSElx,
	input  logic [31:0]             HADDR,
	input  logic [1:0]              HTRANS,
	input  logic [2:0]              HSIZE,
	input  logic                    HWRITE,
	input  logic [31:0]             HWDATA,
	input  logic                    HREADY,
	input  logic [31:0]             crc_out,
	input  logic [31:0]             crc_init_out,
	input  logic [31:0]             crc_poly_out,
	input  logic [7:0]              crc_idr_out,
	input  logic                    buffer_full,
	input  logic                    reset_pending,
	input  logic                    read_wait,
	output logic [31:0]             HRDATA,
	output logic                    HREADYOUT,
	output logic                    HRESP,
	output logic [31:0]             bus_wr,
	output crc_pkg::bus_size_t      bus_size,
	output crc_pkg::poly_size_t     crc_poly_size,
	output crc_pkg::rev_in_t        rev_in_type,
	output logic                    rev_out_type,
	output logic                    crc_init_en,
	output logic                    crc_idr_en,
	output logic                    crc_poly_en,
	output logic                    buffer_write_en,
	output logic                    reset_chain
);
	import crc_pkg::*;

	// Address phase copies
	logic [2:0] haddr_pp;
	bus_size_t  hsize_pp;
	htrans_t    htrans_pp;
	logic       hwrite_pp;
	logic       hselx_pp;

	// Stored CR field
	logic [4:0] crc_cr_ff;

	logic sample_bus;
	logic active;
	logic write_en;
	logic read_en;
	logic dr_wr;
	logic dr_rd;
	logic init_wr;
	logic cr_wr;

	////////////////////////////////////////
	// Address phase pipeline
	////////////////////////////////////////

	// Only move on when the current data phase completes
	assign sample_bus = HREADYOUT && HREADY;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			hselx_pp  <= 1'b0;
			htrans_pp <= HT_IDLE;
		end
		else if (sample_bus)
		begin
			hselx_pp  <= HSElx;
			htrans_pp <= htrans_t'(HTRANS);
		end
	end

	// Payload side of the pipeline
	always_ff @(posedge HCLK)
	begin
		if (sample_bus)
		begin
			haddr_pp  <= HADDR[4:2];
			hsize_pp  <= bus_size_t'(HSIZE[1:0]);
			hwrite_pp <= HWRITE;
		end
	end

	// SEQ and BUSY are ignored
	assign active   = hselx_pp && (htrans_pp == HT_NONSEQ);
	assign write_en = active && hwrite_pp;
	assign read_en  = active && !hwrite_pp;

	////////////////////////////////////////
	// Register decode and strobes
	////////////////////////////////////////

	assign dr_wr   = write_en && (haddr_pp == CRC_DR);
	assign dr_rd   = read_en && (haddr_pp == CRC_DR);
	assign init_wr = write_en && (haddr_pp == CRC_INIT);
	assign cr_wr   = write_en && (haddr_pp == CRC_CR);

	// Push held back while the FIFO is full
	assign buffer_write_en = dr_wr && !buffer_full;
	// INIT write deferred past the chain reload
	assign crc_init_en     = init_wr && !reset_pending;
	assign crc_idr_en      = write_en && (haddr_pp == CRC_IDR);
	assign crc_poly_en     = write_en && (haddr_pp == CRC_POL);

	// Write data comes straight from the data phase
	assign bus_wr   = HWDATA;
	assign bus_size = hsize_pp;

	// Wait states
	assign HREADYOUT = !((dr_wr && buffer_full) ||
	                     (dr_rd && read_wait) ||
	                     (init_wr && reset_pending));
	assign HRESP     = 1'b0;

	// CR holds bits 7:3 of the written word
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			crc_cr_ff <= RESET_CRC_CR;
		else if (cr_wr)
			crc_cr_ff <= HWDATA[7:3];
	end

	// Bit 0 of a CR write restarts the chain
	assign reset_chain   = cr_wr && HWDATA[0];
	assign crc_poly_size = poly_size_t'(crc_cr_ff[1:0]);
	assign rev_in_type   = rev_in_t'(crc_cr_ff[3:2]);
	assign rev_out_type  = crc_cr_ff[4];

	// Read data mux valid in the data phase
	always_comb
	begin
		case (haddr_pp)
			CRC_DR:   HRDATA = crc_out;
			CRC_IDR:  HRDATA = {24'h0, crc_idr_out};
			CRC_CR:   HRDATA = {24'h0, crc_cr_ff, 3'b000};
			CRC_INIT: HRDATA = crc_init_out;
			CRC_POL:  HRDATA = crc_poly_out;
			default:  HRDATA = 32'h0;
		endcase
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	// Strobes only for a selected NONSEQ write
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		(buffer_write_en || crc_init_en || crc_idr_en || crc_poly_en || reset_chain)
		|-> (hselx_pp && hwrite_pp && htrans_pp == HT_NONSEQ));

	// No stall without an active transfer
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		!active |-> HREADYOUT);

endmodule

/* crc_input_buffer.sv */
`timescale 1ns/1ps

module crc_input_buffer
(
	input  logic               HCLK,
	input  logic               HRESETn,
	input  logic               buffer_write_en,
	input  logic [31:0]        bus_wr,
	input  crc_pkg::bus_size_t bus_size,
	input  logic               buf_pop,
	input  logic               reset_chain,
	output logic [31:0]        buf_data,
	output crc_pkg::bus_size_t buf_size,
	output logic               buf_valid,
	output logic               buffer_full
);
	import crc_pkg::*;

	localparam int PTR_W = $clog2(BUF_DEPTH);
	localparam int CNT_W = $clog2(BUF_DEPTH + 1);

	// Word and size storage
	logic [31:0] mem_data [BUF_DEPTH];
	bus_size_t   mem_size [BUF_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	// Pointer and count control, flush wins over everything
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn || reset_chain)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (buffer_write_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (buf_pop)
				rd_ptr <= rd_ptr + 1'b1;
			// Simultaneous push and pop leave the count alone
			if (buffer_write_en && !buf_pop)
				count <= count + 1'b1;
			else if (buf_pop && !buffer_write_en)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge HCLK)
	begin
		if (buffer_write_en)
		begin
			mem_data[wr_ptr] <= bus_wr;
			mem_size[wr_ptr] <= bus_size;
		end
	end

	// Head of queue
	assign buf_data    = mem_data[rd_ptr];
	assign buf_size    = mem_size[rd_ptr];
	assign buf_valid   = (count != '0);
	assign buffer_full = (count == CNT_W'(BUF_DEPTH));

	// Host never pushes into a full FIFO
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		buffer_write_en |-> !buffer_full);

	// Compute unit never pops an empty FIFO
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		buf_pop |-> buf_valid);

endmodule

/* crc_compute_unit.sv */
`timescale 1ns/1ps

module crc_compute_unit
(
	input  logic                HCLK,
	input  logic                HRESETn,
	input  logic [31:0]         bus_wr,
	input  logic                crc_init_en,
	input  logic                crc_poly_en,
	input  logic                crc_idr_en,
	input  crc_pkg::poly_size_t crc_poly_size,
	input  crc_pkg::rev_in_t    rev_in_type,
	input  logic                rev_out_type,
	input  logic                reset_chain,
	input  logic [31:0]         buf_data,
	input  crc_pkg::bus_size_t  buf_size,
	input  logic                buf_valid,
	output logic                buf_pop,
	output logic [31:0]         crc_out,
	output logic [31:0]         crc_init_out,
	output logic [31:0]         crc_poly_out,
	output logic [7:0]          crc_idr_out,
	output logic                reset_pending,
	output logic                read_wait
);
	import crc_pkg::*;

	comp_state_t state;
	logic [1:0]  byte_idx;
	logic [1:0]  byte_last;
	logic [31:0] word_ff;
	logic [31:0] word_rev;
	logic [31:0] crc_ff;
	logic [31:0] crc_next;
	logic [31:0] crc_mask;
	logic [31:0] init_ff;
	logic [31:0] pol_ff;
	logic [7:0]  idr_ff;
	logic [7:0]  cur_byte;
	logic [4:0]  crc_top;
	logic [5:0]  out_shift;

	// Full 32-bit mirror
	function automatic logic [31:0] rev_word(input logic [31:0] w);
		logic [31:0] r;
		for (int i = 0; i < 32; i++)
			r[i] = w[31 - i];
		return r;
	endfunction

	// Mirror within bytes, halfwords or the whole word
	function automatic logic [31:0] rev_input(input logic [31:0] w, input rev_in_t t);
		logic [31:0] r;
		for (int i = 0; i < 32; i++)
		begin
			case (t)
				RI_BYTE: r[i] = w[(i & 24) + 7 - (i & 7)];
				RI_HALF: r[i] = w[(i & 16) + 15 - (i & 15)];
				RI_WORD: r[i] = w[31 - i];
				default: r[i] = w[i];
			endcase
		end
		return r;
	endfunction

	// One byte into an N-bit register with the MSB first
	function automatic logic [31:0] crc_byte(input logic [31:0] c_in, input logic [7:0] d,
		input logic [31:0] pol, input logic [31:0] mask, input logic [4:0] top);
		logic [31:0] c;
		logic        fb;
		c = c_in & mask;
		for (int i = 7; i >= 0; i--)
		begin
			fb = c[top] ^ d[i];
			c  = (c << 1) & mask;
			if (fb)
				c = c ^ (pol & mask);
		end
		return c;
	endfunction

	////////////////////////////////////////
	// Width decode
	////////////////////////////////////////

	always_comb
	begin
		case (crc_poly_size)
			PS_16:
			begin
				crc_mask  = 32'h0000_FFFF;
				crc_top   = 5'd15;
				out_shift = 6'd16;
			end
			PS_8:
			begin
				crc_mask  = 32'h0000_00FF;
				crc_top   = 5'd7;
				out_shift = 6'd24;
			end
			PS_7:
			begin
				crc_mask  = 32'h0000_007F;
				crc_top   = 5'd6;
				out_shift = 6'd25;
			end
			default:
			begin
				crc_mask  = 32'hFFFF_FFFF;
				crc_top   = 5'd31;
				out_shift = 6'd0;
			end
		endcase
	end

	// Byte 0 is folded in the pop cycle and the rest from the held word
	assign word_rev = rev_input(buf_data, rev_in_type);
	assign cur_byte = (state == CS_IDLE) ? word_rev[7:0] : word_ff[{byte_idx, 3'b000} +: 8];
	assign crc_next = crc_byte(crc_ff, cur_byte, pol_ff, crc_mask, crc_top);

	assign buf_pop   = (state == CS_IDLE) && buf_valid && !reset_chain;
	assign read_wait = buf_valid || (state == CS_RUN);

	// Zero-extended result optionally mirrored over N bits
	assign crc_out = rev_out_type ? (rev_word(crc_ff & crc_mask) >> out_shift)
	                              : (crc_ff & crc_mask);

	////////////////////////////////////////
	// FSM and CRC register
	////////////////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			state         <= CS_IDLE;
			byte_idx      <= 2'd0;
			byte_last     <= 2'd0;
			crc_ff        <= RESET_CRC_INIT;
			reset_pending <= 1'b0;
		end
		else
		begin
			reset_pending <= reset_chain;
			if (reset_chain)
			begin
				// Abort and reload from INIT
				state  <= CS_IDLE;
				crc_ff <= init_ff;
			end
			else
			begin
				if (buf_pop)
				begin
					crc_ff    <= crc_next;
					byte_idx  <= 2'd1;
					byte_last <= (buf_size == SZ_HALF) ? 2'd1 : 2'd3;
					state     <= (buf_size == SZ_BYTE) ? CS_IDLE : CS_RUN;
				end
				else if (state == CS_RUN)
				begin
					crc_ff <= crc_next;
					if (byte_idx == byte_last)
						state <= CS_IDLE;
					else
						byte_idx <= byte_idx + 2'd1;
				end
				// INIT write also seeds the CRC
				if (crc_init_en)
					crc_ff <= bus_wr;
			end
		end
	end

	// Reversed word kept for the later bytes
	always_ff @(posedge HCLK)
	begin
		if (buf_pop)
			word_ff <= word_rev;
	end

	// INIT, POL and IDR
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			init_ff <= RESET_CRC_INIT;
			pol_ff  <= RESET_CRC_POL;
			idr_ff  <= RESET_CRC_IDR;
		end
		else
		begin
			if (crc_init_en)
				init_ff <= bus_wr;
			if (crc_poly_en)
				pol_ff <= bus_wr;
			if (crc_idr_en)
				idr_ff <= bus_wr[7:0];
		end
	end

	assign crc_init_out = init_ff;
	assign crc_poly_out = pol_ff;
	assign crc_idr_out  = idr_ff;

	// Pops only from idle with data at the head
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		buf_pop |-> (state == CS_IDLE && buf_valid));

endmodule

/* crc_ip.sv */
`timescale 1ns/1ps

module crc_ip
(
	input  logic        HCLK,
	input  logic        HRESETn,
	input  logic        HSElx,
	input  logic [31:0] HADDR,
	input  logic [1:0]  HTRANS,
	input  logic [2:0]  HSIZE,
	input  logic        HWRITE,
	input  logic [31:0] HWDATA,
	input  logic        HREADY,
	output logic [31:0] HRDATA,
	output logic        HREADYOUT,
	output logic        HRESP
);
	import crc_pkg::*;

	// Host to buffer and compute unit
	logic [31:0] bus_wr;
	bus_size_t   bus_size;
	poly_size_t  crc_poly_size;
	rev_in_t     rev_in_type;
	logic        rev_out_type;
	logic        crc_init_en;
	logic        crc_idr_en;
	logic        crc_poly_en;
	logic        buffer_write_en;
	logic        reset_chain;

	// Buffer to compute unit
	logic [31:0] buf_data;
	bus_size_t   buf_size;
	logic        buf_valid;
	logic        buf_pop;
	logic        buffer_full;

	// Compute unit back to host
	logic [31:0] crc_out;
	logic [31:0] crc_init_out;
	logic [31:0] crc_poly_out;
	logic [7:0]  crc_idr_out;
	logic        reset_pending;
	logic        read_wait;

	crc_host_interface u_host
	(
		.HCLK(HCLK), .HRESETn(HRESETn), .HSElx(HSElx), .HADDR(HADDR),
		.HTRANS(HTRANS), .HSIZE(HSIZE), .HWRITE(HWRITE), .HWDATA(HWDATA),
		.HREADY(HREADY), .crc_out(crc_out), .crc_init_out(crc_init_out),
		.crc_poly_out(crc_poly_out), .crc_idr_out(crc_idr_out),
		.buffer_full(buffer_full), .reset_pending(reset_pending), .read_wait(read_wait),
		.HRDATA(HRDATA), .HREADYOUT(HREADYOUT), .HRESP(HRESP), .bus_wr(bus_wr),
		.bus_size(bus_size), .crc_poly_size(crc_poly_size), .rev_in_type(rev_in_type),
		.rev_out_type(rev_out_type), .crc_init_en(crc_init_en), .crc_idr_en(crc_idr_en),
		.crc_poly_en(crc_poly_en), .buffer_write_en(buffer_write_en),
		.reset_chain(reset_chain)
	);

	// reset_chain doubles as the FIFO flush
	crc_input_buffer u_buffer
	(
		.HCLK(HCLK), .HRESETn(HRESETn), .buffer_write_en(buffer_write_en),
		.bus_wr(bus_wr), .bus_size(bus_size), .buf_pop(buf_pop), .reset_chain(reset_chain),
		.buf_data(buf_data), .buf_size(buf_size), .buf_valid(buf_valid),
		.buffer_full(buffer_full)
	);

	crc_compute_unit u_compute
	(
		.HCLK(HCLK), .HRESETn(HRESETn), .bus_wr(bus_wr), .crc_init_en(crc_init_en),
		.crc_poly_en(crc_poly_en), .crc_idr_en(crc_idr_en), .crc_poly_size(crc_poly_size),
		.rev_in_type(rev_in_type), .rev_out_type(rev_out_type), .reset_chain(reset_chain),
		.buf_data(buf_data), .buf_size(buf_size), .buf_valid(buf_valid), .buf_pop(buf_pop),
		.crc_out(crc_out), .crc_init_out(crc_init_out), .crc_poly_out(crc_poly_out),
		.crc_idr_out(crc_idr_out), .reset_pending(reset_pending), .read_wait(read_wait)
	);

endmodule

/* crc_ip_tb.sv */
`timescale 1ns/1ps

module crc_ip_tb;
	import crc_pkg::*;

	// About ten times the cycles the test sequence needs
	localparam int MAX_CYCLES = 4000;

	logic        HCLK;
	logic        HRESETn;
	logic        HSElx;
	logic [31:0] HADDR;
	logic [1:0]  HTRANS;
	logic [2:0]  HSIZE;
	logic        HWRITE;
	logic [31:0] HWDATA;
	logic        HREADY;
	logic [31:0] HRDATA;
	logic        HREADYOUT;
	logic        HRESP;

	// Stimulus source
	logic [31:0] lfsr;
	// Model of the running chain
	logic [31:0] m_crc;
	logic [31:0] m_pol;
	int          m_width;
	int          m_rev_in;
	logic        m_rev_out;
	// Pending comparisons
	logic [31:0] got_q [$];
	logic [31:0] exp_q [$];
	string       msg_q [$];
	int          errors;
	int          checks;
	int          errors_mark;
	int          test_no;
	int          cycle_count = 0;
	logic        stall_seen;
	// Per-config setup for the size test
	logic [31:0] t4_pol [3] = '{32'h0000_1021, 32'h0000_0007, 32'h0000_0009};
	logic [31:0] t4_init [3] = '{32'h0000_FFFF, 32'h0000_0000, 32'h0000_007F};

	crc_ip DUT
	(
		.HCLK(HCLK), .HRESETn(HRESETn), .HSElx(HSElx), .HADDR(HADDR), .HTRANS(HTRANS),
		.HSIZE(HSIZE), .HWRITE(HWRITE), .HWDATA(HWDATA), .HREADY(HREADY),
		.HRDATA(HRDATA), .HREADYOUT(HREADYOUT), .HRESP(HRESP)
	);

	// Single slave, so HREADY follows the slave
	assign HREADY = HREADYOUT;

	initial HCLK = 1'b0;
	always #50 HCLK = ~HCLK;

	////////////////////////////////////////
	// Stimulus and reference model
	////////////////////////////////////////

	// Right-shifting Galois LFSR with taps 32,22,2,1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per bit
	task automatic rand_bits(input int n, output logic [31:0] v);
		v = 32'h0;
		for (int i = 0; i < n; i++)
		begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// Fold the low nbytes of a word into an N-bit CRC
	function automatic logic [31:0] crc_model(input logic [31:0] crc_in,
		input logic [31:0] word, input int nbytes, input logic [31:0] pol,
		input int width, input int rev_in);
		logic [31:0] w;
		logic [31:0] c;
		logic [31:0] mask;
		logic [7:0]  d;
		logic        fb;
		int          grp;
		mask = (width == 32) ? 32'hFFFF_FFFF : ((32'h1 << width) - 32'h1);
		// Group size of the input mirror
		grp = (rev_in == 1) ? 8 : (rev_in == 2) ? 16 : 32;
		for (int i = 0; i < 32; i++)
			w[i] = (rev_in == 0) ? word[i] : word[(i / grp) * grp + grp - 1 - (i % grp)];
		c = crc_in & mask;
		// LSB byte first, MSB of each byte first
		for (int b = 0; b < nbytes; b++)
		begin
			d = w[8 * b +: 8];
			for (int k = 7; k >= 0; k--)
			begin
				fb = c[width - 1] ^ d[k];
				c  = (c << 1) & mask;
				if (fb)
					c = c ^ (pol & mask);
			end
		end
		return c;
	endfunction

	// Value seen on DR for a given CRC state
	function automatic logic [31:0] crc_result(input logic [31:0] c, input int width,
		input logic rev_out);
		logic [31:0] r;
		r = 32'h0;
		for (int i = 0; i < width; i++)
			r[i] = rev_out ? c[width - 1 - i] : c[i];
		return r;
	endfunction

	function automatic int width_of(input int ps);
		return (ps == 1) ? 16 : (ps == 2) ? 8 : (ps == 3) ? 7 : 32;
	endfunction

	// CR layout has rev_out in bit 7, rev_in in 6:5 and poly size in 4:3
	function automatic logic [31:0] cr_word(input int ps, input int ri, input logic ro);
		return {24'h0, ro, ri[1:0], ps[1:0], 3'b000};
	endfunction

	////////////////////////////////////////
	// AHB master
	////////////////////////////////////////

	task automatic ahb_write(input logic [2:0] offset, input logic [31:0] data,
		input logic [2:0] size);
		HSElx  = 1'b1;
		HADDR  = {27'h0, offset, 2'b00};
		HTRANS = HT_NONSEQ;
		HWRITE = 1'b1;
		HSIZE  = size;
		@(posedge HCLK);
		// Data phase with the bus idle behind it
		@(negedge HCLK);
		HSElx  = 1'b0;
		HTRANS = HT_IDLE;
		HWDATA = data;
		while (!HREADYOUT)
		begin
			stall_seen = 1'b1;
			@(negedge HCLK);
		end
		@(negedge HCLK);
	endtask

	task automatic ahb_read(input logic [2:0] offset, output logic [31:0] data);
		HSElx  = 1'b1;
		HADDR  = {27'h0, offset, 2'b00};
		HTRANS = HT_NONSEQ;
		HWRITE = 1'b0;
		HSIZE  = 3'b010;
		@(posedge HCLK);
		@(negedge HCLK);
		HSElx  = 1'b0;
		HTRANS = HT_IDLE;
		while (!HREADYOUT)
			@(negedge HCLK);
		// Read data is stable for the whole completing cycle
		data = HRDATA;
		@(negedge HCLK);
	endtask

	task automatic push_check(input logic [31:0] got, input logic [31:0] exp,
		input string msg);
		got_q.push_back(got);
		exp_q.push_back(exp);
		msg_q.push_back(msg);
	endtask

	task automatic check_reg(input logic [2:0] offset, input logic [31:0] exp,
		input string msg);
		logic [31:0] got;
		ahb_read(offset, got);
		push_check(got, exp, msg);
	endtask

	task automatic configure(input logic [31:0] pol, input int ps, input int ri,
		input logic ro, input logic [31:0] init);
		ahb_write(CRC_POL, pol, 3'b010);
		// Config plus a chain restart
		ahb_write(CRC_CR, cr_word(ps, ri, ro) | 32'h1, 3'b010);
		ahb_write(CRC_INIT, init, 3'b010);
		m_crc     = init;
		m_pol     = pol;
		m_width   = width_of(ps);
		m_rev_in  = ri;
		m_rev_out = ro;
	endtask

	// DR write of random data that the model follows
	task automatic feed(input logic [2:0] size);
		logic [31:0] v;
		rand_bits(8 << size, v);
		ahb_write(CRC_DR, v, size);
		m_crc = crc_model(m_crc, v, 1 << size, m_pol, m_width, m_rev_in);
	endtask

	task automatic check_dr(input string msg);
		check_reg(CRC_DR, crc_result(m_crc, m_width, m_rev_out), msg);
	endtask

	task automatic finish_test(input string name);
		// Let the compare process drain
		@(posedge HCLK);
		@(negedge HCLK);
		test_no++;
		$display("Test %0d %s: %0d errors", test_no, name, errors - errors_mark);
		errors_mark = errors;
	endtask

	////////////////////////////////////////
	// Checkers and timeout
	////////////////////////////////////////

	always @(posedge HCLK)
	begin
		logic [31:0] got;
		logic [31:0] exp;
		string       msg;
		while (got_q.size() > 0)
		begin
			got = got_q.pop_front();
			exp = exp_q.pop_front();
			msg = msg_q.pop_front();
			checks++;
			assert (got == exp)
			else
			begin
				$display("FAIL t=%0t: %s read %h expected %h", $time, msg, got, exp);
				errors++;
			end
		end
	end

	// No error responses at any time
	always @(negedge HCLK)
	begin
		if (HRESETn)
			assert (HRESP == 1'b0)
			else
			begin
				$display("FAIL t=%0t: HRESP is %b expected 0", $time, HRESP);
				errors++;
			end
	end

	always @(posedge HCLK)
	begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES)
		begin
			$display("Timeout after %0d cycles, the test sequence did not complete",
				cycle_count);
			$display("Errors found");
			$finish;
		end
	end

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial
	begin
		logic [31:0] v;
		logic [31:0] init;
		HRESETn     = 1'b0;
		HSElx       = 1'b0;
		HADDR       = 32'h0;
		HTRANS      = HT_IDLE;
		HSIZE       = 3'b010;
		HWRITE      = 1'b0;
		HWDATA      = 32'h0;
		lfsr        = 32'hfa48_e969;
		errors      = 0;
		checks      = 0;
		errors_mark = 0;
		test_no     = 0;
		stall_seen  = 1'b0;
		repeat (16) @(negedge HCLK);
		HRESETn = 1'b1;
		@(negedge HCLK);

		// Reset values
		check_reg(CRC_CR, 32'h0000_0000, "CR reset");
		check_reg(CRC_INIT, 32'hFFFF_FFFF, "INIT reset");
		check_reg(CRC_POL, 32'h04C1_1DB7, "POL reset");
		check_reg(CRC_IDR, 32'h0000_0000, "IDR reset");
		check_reg(CRC_DR, 32'hFFFF_FFFF, "DR reset");
		finish_test("reset values");

		// Register access
		rand_bits(32, v);
		ahb_write(CRC_INIT, v, 3'b010);
		check_reg(CRC_INIT, v, "INIT readback");
		rand_bits(32, v);
		ahb_write(CRC_POL, v, 3'b010);
		check_reg(CRC_POL, v, "POL readback");
		rand_bits(32, v);
		ahb_write(CRC_IDR, v, 3'b010);
		check_reg(CRC_IDR, {24'h0, v[7:0]}, "IDR readback");
		ahb_write(CRC_CR, 32'hFFFF_FFFE, 3'b010);
		check_reg(CRC_CR, 32'h0000_00F8, "CR readback");
		// Bit 0 is a strobe and reads zero
		ahb_write(CRC_CR, 32'h0000_00A9, 3'b010);
		check_reg(CRC_CR, 32'h0000_00A8, "CR bit 0");
		finish_test("register access");

		// CRC-32 stream that fills the FIFO
		configure(32'h04C1_1DB7, 0, 0, 1'b0, 32'hFFFF_FFFF);
		stall_seen = 1'b0;
		for (int i = 0; i < 16; i++)
			feed(3'b010);
		check_dr("CRC-32 stream");
		push_check({31'h0, stall_seen}, 32'h1, "HREADYOUT low during stream");
		finish_test("crc32 stream");

		// Byte and halfword writes with narrow polynomials
		for (int k = 0; k < 3; k++)
		begin
			configure(t4_pol[k], k + 1, 0, 1'b0, t4_init[k]);
			for (int i = 0; i < 3; i++)
				feed(3'b000);
			feed(3'b001);
			feed(3'b001);
			feed(3'b010);
			check_dr($sformatf("DR width %0d", width_of(k + 1)));
		end
		finish_test("sizes and widths");

		// Every input mirror with the output mirror on and off
		for (int ri = 0; ri < 4; ri++)
		begin
			for (int ro = 0; ro < 2; ro++)
			begin
				if (ri % 2 == 0)
					configure(32'h04C1_1DB7, 0, ri, ro[0], 32'hFFFF_FFFF);
				else
					configure(32'h0000_1021, 1, ri, ro[0], 32'h0000_FFFF);
				feed(3'b010);
				feed(3'b010);
				check_dr($sformatf("DR rev_in %0d rev_out %0d", ri, ro));
			end
		end
		finish_test("reversal");

		// Chain restart in the middle of a stream
		rand_bits(32, init);
		configure(32'h04C1_1DB7, 0, 1, 1'b1, init);
		for (int i = 0; i < 3; i++)
			feed(3'b010);
		ahb_write(CRC_CR, cr_word(0, 1, 1'b1) | 32'h1, 3'b010);
		m_crc = init;
		for (int i = 0; i < 4; i++)
			feed(3'b010);
		check_dr("DR after restart");
		finish_test("chain restart");

		$display("Summary: %0d tests, %0d checks, %0d errors", test_no, checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

/* crc_ip.f */
crc_pkg.sv
crc_host_interface.sv
crc_input_buffer.sv
crc_compute_unit.sv
crc_ip.sv
crc_ip_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the CRC peripheral testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module crc_ip_tb \
	-f crc_ip.f -o sim_crc_ip
./obj_dir/sim_crc_ip | tee sim.log

if grep -q "^No errors$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
